/* clahe_cdf_top.sv */
// CLAHE between-frame CDF stage top
// tile reader -> clip/CDF engine -> LUT writer
`include "clahe_params.svh"
`default_nettype none

module clahe_cdf_top #(
    parameter int tile_num = `CLAHE_TILE_NUM_DEF
) (
    input  logic                     pclk,
    input  logic                     rst_n,
    input  logic                     frame_hist_done,  // one-cycle start
    input  logic [`CLAHE_CNT_W-1:0]  clip_limit,
    input  logic                     ping_pong_flag,   // 0 RAM A, 1 RAM B
    output clahe_pkg::hist_rd_t      hist_rd,
    input  logic [`CLAHE_CNT_W-1:0]  hist_rd_data_a,
    input  logic [`CLAHE_CNT_W-1:0]  hist_rd_data_b,
    output clahe_pkg::lut_wr_t       lut_wr,
    output logic                     cdf_done,
    output logic                     processing
);
    import clahe_pkg::*;

    // ==================================================
    // inter-stage wires
    // ==================================================
    logic        bin_req;
    logic        bin_ack;
    bin_word_t   bin_word;
    logic        rd_tile_last;     // reader flags last tile
    logic        cdf_req;
    logic        cdf_ack;
    cdf_word_t   cdf_word;
    tile_stats_t stats;
    logic        cdf_tile_last;    // final word of last tile
    logic        run_done;

    clahe_tile_reader #(.tile_num(tile_num)) clahe_tile_reader_inst (
        .pclk, .rst_n, .frame_hist_done, .ping_pong_flag, .hist_rd,
        .hist_rd_data_a, .hist_rd_data_b, .bin_req, .bin_ack, .bin_word,
        .tile_last(rd_tile_last), .processing, .run_done
    );

    clahe_clip_cdf clahe_clip_cdf_inst (
        .pclk, .rst_n, .clip_limit, .bin_req, .tile_last_in(rd_tile_last),
        .bin_ack, .bin_word, .cdf_req, .cdf_ack, .cdf_word, .stats,
        .tile_last(cdf_tile_last)
    );

    clahe_lut_writer clahe_lut_writer_inst (
        .pclk, .rst_n, .cdf_req, .tile_last(cdf_tile_last), .cdf_ack,
        .cdf_word, .stats, .lut_wr, .cdf_done, .run_done
    );

endmodule

`default_nettype wire

/* clahe_clip_cdf.sv */
// clip and CDF engine: clips incoming bins, buffers one tile,
// accumulates the redistributed CDF and streams it with tile stats
`include "clahe_params.svh"
`default_nettype none

module clahe_clip_cdf (
    input  logic                     pclk,
    input  logic                     rst_n,
    input  logic [`CLAHE_CNT_W-1:0]  clip_limit,
    input  logic                     bin_req,
    input  logic                     tile_last_in,
    output logic                     bin_ack,
    input  clahe_pkg::bin_word_t     bin_word,
    output logic                     cdf_req,
    input  logic                     cdf_ack,
    output clahe_pkg::cdf_word_t     cdf_word,
    output clahe_pkg::tile_stats_t   stats,
    output logic                     tile_last
);
    import clahe_pkg::*;

    typedef enum logic [1:0] {
        S_RECV,     // accept 256 bins
        S_CDF,      // fixed 256-cycle accumulate
        S_SEND      // stream cdf words
    } eng_state_t;

    eng_state_t              state;

    logic [`CLAHE_CNT_W-1:0] clip_buf [0:`CLAHE_BINS-1];
    logic [`CLAHE_CDF_W-1:0] cdf_buf  [0:`CLAHE_BINS-1];

    logic [`CLAHE_CDF_W-1:0] excess_total;
    logic [`CLAHE_CNT_W-1:0] excess_per_bin;
    logic [`CLAHE_CNT_W-1:0] clip_cnt;
    logic [`CLAHE_CNT_W-1:0] excess_in;
    logic [`CLAHE_BIN_W-1:0] pass_cnt;
    logic [`CLAHE_BIN_W-1:0] out_cnt;
    logic [`CLAHE_CDF_W-1:0] acc;
    logic [`CLAHE_CDF_W-1:0] acc_next;
    logic [`CLAHE_CDF_W-1:0] min_q;
    logic [`CLAHE_CDF_W-1:0] max_q;
    logic                    min_found;
    logic [`CLAHE_TILE_W-1:0] tile_q;
    logic                    last_q;
    logic                    bin_take;
    logic                    send_load;

    // ==================================================
    // clip and redistribution arithmetic
    // ==================================================
    assign clip_cnt       = (bin_word.count > clip_limit) ? clip_limit : bin_word.count;
    assign excess_in      = bin_word.count - clip_cnt;
    assign excess_per_bin = excess_total[`CLAHE_CDF_W-1:8];   // total / 256

    // redistribution folded into the running sum
    assign acc_next = acc + `CLAHE_CDF_W'(clip_buf[pass_cnt])
                          + `CLAHE_CDF_W'(excess_per_bin);

    assign bin_take  = (state == S_RECV) && bin_req && !bin_ack;
    assign send_load = (state == S_SEND) && !cdf_req && !cdf_ack;

    assign stats     = '{cdf_min: min_q, cdf_range: max_q - min_q};
    assign tile_last = last_q && cdf_req && (cdf_word.bin == '1);  // final word only

    always_ff @(posedge pclk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= S_RECV;
            bin_ack      <= 1'b0;
            cdf_req      <= 1'b0;
            excess_total <= '0;
            pass_cnt     <= '0;
            out_cnt      <= '0;
            acc          <= '0;
            min_q        <= '0;
            max_q        <= '0;
            min_found    <= 1'b0;
            tile_q       <= '0;
            last_q       <= 1'b0;
        end else begin
            // bin side ack, drops once req is gone
            if (bin_take)
                bin_ack <= 1'b1;
            else if (!bin_req)
                bin_ack <= 1'b0;

            case (state)
                S_RECV: begin
                    if (bin_take) begin
                        excess_total <= excess_total + `CLAHE_CDF_W'(excess_in);
                        tile_q       <= bin_word.tile;
                        last_q       <= tile_last_in;
                        if (bin_word.bin == '1) begin   // bin 255 in
                            state     <= S_CDF;
                            pass_cnt  <= '0;
                            acc       <= '0;
                            min_q     <= '0;
                            min_found <= 1'b0;
                        end
                    end
                end
                S_CDF: begin
                    acc      <= acc_next;
                    pass_cnt <= pass_cnt + `CLAHE_BIN_W'(1);
                    if (!min_found && (acc_next != '0)) begin
                        min_q     <= acc_next;         // first nonzero cdf
                        min_found <= 1'b1;
                    end
                    if (pass_cnt == '1) begin
                        max_q   <= acc_next;           // last bin cdf
                        out_cnt <= '0;
                        state   <= S_SEND;
                    end
                end
                S_SEND: begin
                    if (send_load)
                        cdf_req <= 1'b1;
                    if (cdf_req && cdf_ack) begin
                        cdf_req <= 1'b0;
                        out_cnt <= out_cnt + `CLAHE_BIN_W'(1);
                        if (out_cnt == '1) begin
                            excess_total <= '0;        // fresh tile
                            state        <= S_RECV;
                        end
                    end
                end
                default: state <= S_RECV;
            endcase
        end
    end

    // tile buffers and outgoing word
    always_ff @(posedge pclk) begin
        if (bin_take)
            clip_buf[bin_word.bin] <= clip_cnt;
        if (state == S_CDF)
            cdf_buf[pass_cnt] <= acc_next;
        if (send_load) begin
            cdf_word.tile <= tile_q;
            cdf_word.bin  <= out_cnt;
            cdf_word.cdf  <= cdf_buf[out_cnt];
        end
    end

endmodule

`default_nettype wire

/* clahe_lut_writer.sv */
// LUT writer: shift-normalizes each CDF value into an 8-bit gray,
// writes the CDF LUT and flags the end of the run
`include "clahe_params.svh"
`default_nettype none

module clahe_lut_writer (
    input  logic                     pclk,
    input  logic                     rst_n,
    input  logic                     cdf_req,
    input  logic                     tile_last,
    output logic                     cdf_ack,
    input  clahe_pkg::cdf_word_t     cdf_word,
    input  clahe_pkg::tile_stats_t   stats,
    output clahe_pkg::lut_wr_t       lut_wr,
    output logic                     cdf_done,
    output logic                     run_done
);
    import clahe_pkg::*;

    logic                      cap_take;
    logic                      cap_vld;
    cdf_word_t                 cap_word;
    logic                      cap_last;

    logic                      s1_vld;
    logic [`CLAHE_TILE_W-1:0]  s1_tile;
    logic [`CLAHE_BIN_W-1:0]   s1_bin;
    logic                      s1_last;
    logic [`CLAHE_CDF_W-1:0]   s1_diff;
    logic [4:0]                s1_shift;
    logic                      s1_flat;
    logic                      s1_below;

    logic [4:0]                shift_sel;
    logic [`CLAHE_CDF_W+7:0]   scaled;
    logic [`CLAHE_LUT_W-1:0]   mapped;

    assign cap_take = cdf_req && !cdf_ack;

    // ==================================================
    // normalization
    // ==================================================
    // one more bit of shift per doubling of the range
    always_comb begin
        shift_sel = 5'(`CLAHE_SHIFT_MIN);
        for (int k = `CLAHE_SHIFT_MIN; k < `CLAHE_SHIFT_MAX; k++) begin
            if (stats.cdf_range >= (`CLAHE_CDF_W'(1) << k))
                shift_sel = 5'(k + 1);
        end
    end

    assign scaled = {s1_diff, 8'h00} >> s1_shift;   // (cdf - min) * 256 >> shift

    always_comb begin
        if (s1_flat)
            mapped = `CLAHE_LUT_W'(`CLAHE_FLAT_GRAY);
        else if (s1_below)
            mapped = '0;                              // no underflow wrap
        else if (|scaled[`CLAHE_CDF_W+7:`CLAHE_LUT_W])
            mapped = '1;                              // saturate
        else
            mapped = scaled[`CLAHE_LUT_W-1:0];
    end

    always_ff @(posedge pclk or negedge rst_n) begin
        if (!rst_n) begin
            cdf_ack  <= 1'b0;
            cap_vld  <= 1'b0;
            s1_vld   <= 1'b0;
            lut_wr   <= '0;
            run_done <= 1'b0;
            cdf_done <= 1'b0;
        end else begin
            if (cap_take)
                cdf_ack <= 1'b1;
            else if (!cdf_req)
                cdf_ack <= 1'b0;
            cap_vld     <= cap_take;
            s1_vld      <= cap_vld;
            lut_wr.en   <= s1_vld;                    // two cycles after capture
            lut_wr.tile <= s1_tile;
            lut_wr.bin  <= s1_bin;
            lut_wr.data <= mapped;
            run_done    <= s1_vld && s1_last;         // with the final write
            cdf_done    <= run_done;
        end
    end

    // capture and stage-1 payload
    always_ff @(posedge pclk) begin
        if (cap_take) begin
            cap_word <= cdf_word;
            cap_last <= tile_last;
        end
        s1_tile  <= cap_word.tile;
        s1_bin   <= cap_word.bin;
        s1_last  <= cap_last;
        s1_diff  <= cap_word.cdf - stats.cdf_min;
        s1_shift <= shift_sel;
        s1_flat  <= (stats.cdf_range == '0);
        s1_below <= (cap_word.cdf < stats.cdf_min);
    end

endmodule

`default_nettype wire

/* clahe_params.svh */
// CLAHE CDF stage constants
// bin count, datapath widths, default tile count, normalization limits
`ifndef CLAHE_PARAMS_SVH
`define CLAHE_PARAMS_SVH

// ==================================================
// tile geometry
// ==================================================
`define CLAHE_BINS          256     // bins per tile
`define CLAHE_BIN_W         8       // bin address
`define CLAHE_TILE_W        4       // up to 16 tiles
`define CLAHE_TILE_NUM_DEF  16

// ==================================================
// datapath widths and normalization
// ==================================================
`define CLAHE_CNT_W         16      // histogram count
`define CLAHE_CDF_W         24      // cdf accumulator
`define CLAHE_LUT_W         8       // mapped gray value
`define CLAHE_FLAT_GRAY     128     // flat tile maps to mid gray
`define CLAHE_SHIFT_MIN     8       // range below 256
`define CLAHE_SHIFT_MAX     16      // range at or above 32768

`endif

/* clahe_pkg.sv */
// shared packed structs for the CLAHE CDF stage
// histogram read, bin and cdf hand-off words, tile stats, LUT write
`include "clahe_params.svh"
`default_nettype none

package clahe_pkg;

    // histogram RAM read request
    typedef struct packed {
        logic [`CLAHE_TILE_W-1:0] tile;
        logic [`CLAHE_BIN_W-1:0]  bin;
    } hist_rd_t;

    // reader -> engine
    typedef struct packed {
        logic [`CLAHE_TILE_W-1:0] tile;
        logic [`CLAHE_BIN_W-1:0]  bin;
        logic [`CLAHE_CNT_W-1:0]  count;
    } bin_word_t;

    // engine -> writer
    typedef struct packed {
        logic [`CLAHE_TILE_W-1:0] tile;
        logic [`CLAHE_BIN_W-1:0]  bin;
        logic [`CLAHE_CDF_W-1:0]  cdf;
    } cdf_word_t;

    typedef struct packed {
        logic [`CLAHE_CDF_W-1:0]  cdf_min;      // first nonzero cdf
        logic [`CLAHE_CDF_W-1:0]  cdf_range;    // last cdf minus cdf_min
    } tile_stats_t;

    typedef struct packed {
        logic                     en;
        logic [`CLAHE_TILE_W-1:0] tile;
        logic [`CLAHE_BIN_W-1:0]  bin;
        logic [`CLAHE_LUT_W-1:0]  data;
    } lut_wr_t;

endpackage

`default_nettype wire

/* clahe_tile_reader.sv */
// tile reader: walks tiles and bins, reads the ping-pong histogram RAM,
// hands each bin to the clip/CDF engine over a four-phase req/ack
`include "clahe_params.svh"
`default_nettype none

module clahe_tile_reader #(
    parameter int tile_num = `CLAHE_TILE_NUM_DEF
) (
    input  logic                     pclk,
    input  logic                     rst_n,
    input  logic                     frame_hist_done,
    input  logic                     ping_pong_flag,
    output clahe_pkg::hist_rd_t      hist_rd,
    input  logic [`CLAHE_CNT_W-1:0]  hist_rd_data_a,
    input  logic [`CLAHE_CNT_W-1:0]  hist_rd_data_b,
    output logic                     bin_req,
    input  logic                     bin_ack,
    output clahe_pkg::bin_word_t     bin_word,
    output logic                     tile_last,
    output logic                     processing,
    input  logic                     run_done
);
    import clahe_pkg::*;

    typedef enum logic [2:0] {
        R_IDLE,     // wait for start pulse
        R_ADDR,     // address on hist_rd
        R_DATA,     // RAM data valid this cycle
        R_HAND,     // req high, wait ack
        R_RUN       // all bins sent, wait for writer
    } rd_state_t;

    rd_state_t               state;
    logic [`CLAHE_CNT_W-1:0] rd_data;
    logic                    last_tile;

    assign rd_data   = ping_pong_flag ? hist_rd_data_b : hist_rd_data_a;  // 0 -> RAM A
    assign last_tile = (hist_rd.tile == `CLAHE_TILE_W'(tile_num - 1));

    // ==================================================
    // sequencing and handshake
    // ==================================================
    always_ff @(posedge pclk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= R_IDLE;
            hist_rd    <= '0;
            bin_req    <= 1'b0;
            processing <= 1'b0;
        end else begin
            case (state)
                R_IDLE: begin
                    if (frame_hist_done) begin     // start ignored unless idle
                        processing <= 1'b1;
                        hist_rd    <= '0;          // tile 0 bin 0
                        state      <= R_ADDR;
                    end
                end
                R_ADDR: state <= R_DATA;          // one-cycle RAM latency
                R_DATA: begin
                    // four-phase rule: previous ack must be gone
                    if (!bin_ack) begin
                        bin_req <= 1'b1;
                        state   <= R_HAND;
                    end
                end
                R_HAND: begin
                    if (bin_ack) begin
                        bin_req <= 1'b0;
                        if (hist_rd.bin == '1) begin
                            if (last_tile) begin
                                state <= R_RUN;
                            end else begin
                                hist_rd.tile <= hist_rd.tile + `CLAHE_TILE_W'(1);
                                hist_rd.bin  <= '0;
                                state        <= R_ADDR;
                            end
                        end else begin
                            hist_rd.bin <= hist_rd.bin + `CLAHE_BIN_W'(1);
                            state       <= R_ADDR;
                        end
                    end
                end
                R_RUN: begin
                    if (run_done) begin            // last LUT write done
                        processing <= 1'b0;
                        state      <= R_IDLE;
                    end
                end
                default: state <= R_IDLE;
            endcase
        end
    end

    // latch returned count, stays put while req is high
    always_ff @(posedge pclk) begin
        if (state == R_DATA) begin
            bin_word.tile  <= hist_rd.tile;
            bin_word.bin   <= hist_rd.bin;
            bin_word.count <= rd_data;
            tile_last      <= last_tile;
        end
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+.
clahe_pkg.sv
clahe_tile_reader.sv
clahe_clip_cdf.sv
clahe_lut_writer.sv
clahe_cdf_top.sv
tb_clahe_cdf.sv

/* run_sim.sh */
#!/bin/sh
# build and run the CLAHE CDF testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tb_clahe_cdf -f project.f > build.log 2>&1 \
    && ./obj_dir/Vtb_clahe_cdf > sim.log 2>&1
grep -q "^STATUS: PASS$" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }

/* tb_clahe_cdf.sv */
// testbench for the CLAHE CDF stage
// clock, reset, ping-pong histogram RAM model, random stimulus,
// reference model of clip, CDF and normalization, LUT scoreboard
`include "clahe_params.svh"
`default_nettype none

module tb_clahe_cdf;
    timeunit 1ns;
    timeprecision 1ps;

    import clahe_pkg::*;

    localparam int tile_cnt  = 3;
    localparam int lut_total = tile_cnt * `CLAHE_BINS;
    localparam int ram_depth = 1 << (`CLAHE_TILE_W + `CLAHE_BIN_W);
    localparam int rd_last   = lut_total - 1;          // final read address of a run
    localparam int wait_max  = 60000;                  // cycles for one run

    logic                    pclk = 1'b0;
    logic                    rst_n;
    logic                    frame_hist_done;
    logic [`CLAHE_CNT_W-1:0] clip_limit;
    logic                    ping_pong_flag;
    hist_rd_t                hist_rd;
    logic [`CLAHE_CNT_W-1:0] hist_rd_data_a = '0;
    logic [`CLAHE_CNT_W-1:0] hist_rd_data_b = '0;
    lut_wr_t                 lut_wr;
    logic                    cdf_done;
    logic                    processing;

    logic [`CLAHE_CNT_W-1:0] ram_a    [0:ram_depth-1];
    logic [`CLAHE_CNT_W-1:0] ram_b    [0:ram_depth-1];
    logic [`CLAHE_LUT_W-1:0] exp_lut  [0:lut_total-1];  // model output
    logic [`CLAHE_LUT_W-1:0] got_data [0:lut_total-1];
    int                      got_run  [0:lut_total-1];  // run that wrote the entry
    int                      total_wr;                  // all LUT writes seen
    int                      run_base;                  // total_wr at run start
    int                      run_id;
    int unsigned             seed_val;
    string                   test_name;
    int                      wr_idx;
    lut_wr_t                 exp_wr;
    hist_rd_t                rd_prev;
    hist_rd_t                rd_exp;

    clahe_cdf_top #(.tile_num(tile_cnt)) clahe_cdf_top_inst (
        .pclk, .rst_n, .frame_hist_done, .clip_limit, .ping_pong_flag, .hist_rd,
        .hist_rd_data_a, .hist_rd_data_b, .lut_wr, .cdf_done, .processing
    );

    always #2 pclk = ~pclk;                             // 4 ns period

    // histogram RAM pair, data one cycle after the address
    always @(posedge pclk) begin
        hist_rd_data_a <= ram_a[hist_rd];
        hist_rd_data_b <= ram_b[hist_rd];
    end

    // ==================================================
    // failure reporting and compare tasks
    // ==================================================
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_lut(input lut_wr_t expected, input lut_wr_t actual, input string what);
        if (actual !== expected)
            abort_run($sformatf("error: %s %s tile %0d bin %0d expected %h actual %h",
                                test_name, what, expected.tile, expected.bin, expected, actual));
    endtask

    task automatic check_addr(input hist_rd_t expected, input hist_rd_t actual,
                              input string what);
        if (actual !== expected)
            abort_run($sformatf("error: %s %s expected tile %0d bin %0d actual tile %0d bin %0d",
                                test_name, what, expected.tile, expected.bin,
                                actual.tile, actual.bin));
    endtask

    task automatic check_flag(input logic actual, input logic expected, input string what);
        if (actual !== expected)
            abort_run($sformatf("error: %s %s expected %b actual %b",
                                test_name, what, expected, actual));
    endtask

    task automatic check_count(input int expected, input int actual, input string what);
        if (actual != expected)
            abort_run($sformatf("error: %s %s expected %0d actual %0d",
                                test_name, what, expected, actual));
    endtask

    // ==================================================
    // reference model: clip, spread excess, CDF, shift normalize
    // ==================================================
    task automatic build_model(input logic sel_b, input logic [`CLAHE_CNT_W-1:0] clip);
        int clipped [0:`CLAHE_BINS-1];
        int cdf_v   [0:`CLAHE_BINS-1];
        int clip_i;
        int cnt;
        int excess;
        int acc;
        int cmin;
        int crange;
        int shift;
        int r;
        int v;
        bit found;
        clip_i = int'(clip);
        for (int t = 0; t < tile_cnt; t++) begin
            excess = 0;
            for (int b = 0; b < `CLAHE_BINS; b++) begin
                cnt = sel_b ? int'(ram_b[t * `CLAHE_BINS + b]) : int'(ram_a[t * `CLAHE_BINS + b]);
                clipped[b] = (cnt > clip_i) ? clip_i : cnt;
                excess     = excess + cnt - clipped[b];
            end
            acc   = 0;
            cmin  = 0;
            found = 1'b0;
            for (int b = 0; b < `CLAHE_BINS; b++) begin
                acc      = acc + clipped[b] + excess / `CLAHE_BINS;  // even share per bin
                cdf_v[b] = acc;
                if (!found && acc != 0) begin
                    cmin  = acc;
                    found = 1'b1;
                end
            end
            crange = cdf_v[`CLAHE_BINS-1] - cmin;
            shift  = `CLAHE_SHIFT_MIN;
            r      = crange / 256;
            while (r > 0 && shift < `CLAHE_SHIFT_MAX) begin
                shift = shift + 1;                         // one per doubling
                r     = r / 2;
            end
            for (int b = 0; b < `CLAHE_BINS; b++) begin
                if (crange == 0)
                    v = `CLAHE_FLAT_GRAY;
                else if (cdf_v[b] < cmin)
                    v = 0;
                else
                    v = ((cdf_v[b] - cmin) * 256) >> shift;
                if (v > 255)
                    v = 255;
                exp_lut[t * `CLAHE_BINS + b] = `CLAHE_LUT_W'(v);
            end
        end
    endtask

    // read address steps one bin at a time, back to tile 0 bin 0 for a new run
    always @(negedge pclk) begin
        if (rst_n === 1'b1 && hist_rd !== rd_prev) begin
            if (int'(rd_prev) == rd_last)
                rd_exp = '0;
            else
                rd_exp = 12'(int'(rd_prev) + 1);
            check_addr(rd_exp, hist_rd, "histogram read address");
        end
        rd_prev = hist_rd;
    end

    // scoreboard, samples LUT writes away from the clock edge
    // writes come tile by tile, bins ascending
    always @(negedge pclk) begin
        if (rst_n === 1'b1 && lut_wr.en === 1'b1) begin
            wr_idx = total_wr - run_base;
            if (wr_idx >= lut_total) begin
                abort_run($sformatf("%s: more LUT writes than bins in the run", test_name));
            end else begin
                exp_wr.en   = 1'b1;
                exp_wr.tile = `CLAHE_TILE_W'(wr_idx / `CLAHE_BINS);
                exp_wr.bin  = `CLAHE_BIN_W'(wr_idx % `CLAHE_BINS);
                exp_wr.data = exp_lut[wr_idx];
                check_lut(exp_wr, lut_wr, "lut entry");
                got_run[wr_idx]  = run_id;
                got_data[wr_idx] = lut_wr.data;
                total_wr         = total_wr + 1;
            end
        end
    end

    // one frame: start pulse, optional start while busy, wait for cdf_done
    task automatic run_frame(input string name, input logic sel_b,
                             input logic [`CLAHE_CNT_W-1:0] clip, input bit poke);
        int   cyc;
        logic last_en;
        test_name = name;
        run_id    = run_id + 1;
        build_model(sel_b, clip);
        run_base = total_wr;
        @(posedge pclk);
        clip_limit      <= clip;
        ping_pong_flag  <= sel_b;
        frame_hist_done <= 1'b1;
        @(posedge pclk);
        frame_hist_done <= 1'b0;
        cyc = 0;
        do begin
            @(negedge pclk);
            cyc++;
            if (cyc > 8)
                abort_run($sformatf("%s: processing did not rise after the start", name));
        end while (processing !== 1'b1);
        if (poke) begin
            repeat (40) @(posedge pclk);
            frame_hist_done <= 1'b1;                       // busy, must be ignored
            @(posedge pclk);
            frame_hist_done <= 1'b0;
            @(negedge pclk);
            check_flag(processing, 1'b1, "busy during extra start");
        end
        cyc     = 0;
        last_en = 1'b0;
        do begin
            @(negedge pclk);
            cyc++;
            if (cyc > wait_max)
                abort_run($sformatf("%s: no cdf_done within %0d cycles", name, wait_max));
            if (cdf_done !== 1'b1)
                last_en = lut_wr.en;
        end while (cdf_done !== 1'b1);
        check_flag(last_en, 1'b1, "final write one cycle before cdf_done");
        check_flag(processing, 1'b0, "processing low with cdf_done");
        @(negedge pclk);
        check_flag(cdf_done, 1'b0, "cdf_done single cycle");
        repeat (20) @(negedge pclk);
        check_flag(processing, 1'b0, "no restart after the run");
        check_count(lut_total, total_wr - run_base, "lut writes");
    endtask

    // ==================================================
    // stimulus
    // ==================================================
    initial begin
        lut_wr_t flat_exp;
        lut_wr_t flat_got;
        rst_n           <= 1'b0;
        frame_hist_done <= 1'b0;
        clip_limit      <= '0;
        ping_pong_flag  <= 1'b0;
        seed_val = $urandom(32'hf9af_3f49);                // seeded once
        for (int i = 0; i < ram_depth; i++) begin
            ram_a[i] = `CLAHE_CNT_W'($urandom % 2000);
            ram_b[i] = `CLAHE_CNT_W'($urandom % 2000);
        end
        repeat (3) @(posedge pclk);
        rst_n <= 1'b1;
        repeat (2) @(posedge pclk);

        run_frame("clip_ram_a", 1'b0, 16'd900, 1'b1);
        run_frame("clip_ram_b", 1'b1, 16'd900, 1'b0);
        run_frame("no_clip", 1'b0, 16'hffff, 1'b0);

        // tile 1 with one nonzero bin, excess too small to spread
        for (int b = 0; b < `CLAHE_BINS; b++)
            ram_a[`CLAHE_BINS + b] = '0;
        ram_a[`CLAHE_BINS + 77] = 16'd1000;
        run_frame("flat_tile", 1'b0, 16'd900, 1'b1);
        for (int b = 0; b < `CLAHE_BINS; b++) begin
            flat_exp.en   = 1'b1;
            flat_exp.tile = `CLAHE_TILE_W'(1);
            flat_exp.bin  = `CLAHE_BIN_W'(b);
            flat_exp.data = `CLAHE_LUT_W'(`CLAHE_FLAT_GRAY);
            flat_got      = flat_exp;
            flat_got.en   = (got_run[`CLAHE_BINS + b] == run_id);
            flat_got.data = got_data[`CLAHE_BINS + b];
            check_lut(flat_exp, flat_got, "flat tile entry");
        end

        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire
